/* src.f */
design/id_pkg.sv
design/id_ctrl_if.sv
design/id_decoder.sv
design/id_operands.sv
design/id_flow_ctrl.sv
design/id_ex_pipe.sv
design/id_stage.sv
testbench/id_stage_chk.sv
testbench/tb_id_stage.sv

/* Makefile */
SOURCES := $(wildcard design/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_id_stage: src.f $(SOURCES)
	verilator --binary --assert --timing -j 0 --top-module tb_id_stage -f src.f

run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage;
  import id_pkg::*;

  localparam int NUM_ROWS  = 18;
  localparam int CLK_HALF  = 20;
  localparam int ROW_LIMIT = 20;

  // One instruction with its expected decode
  typedef struct {
    logic [31:0] instr;
    int          fwa, fwb;
    int          stall;
    int          kill;
    alu_op_e     op;
    int          en;    // alu, lsu, lsu_we, rf_we, illegal
    int          re;
    int          lsu;   // sext, size
    int          asrc;  // 1 rs1, 2 pc, 3 zero
    int          bsrc;  // 1 rs2, 2 immediate
    logic [31:0] bimm;
    int          csrc;  // 1 rs2, 2 pc plus offset
    logic [31:0] off;   // branch or jump offset
    int          tsrc;  // 1 JAL, 2 JALR
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{32'h002081b3, 0, 0, 0, 0, ALU_ADD, 'b10010, 3, 0, 1, 1, 0, 0, 0, 0},
    '{32'h407302b3, 1, 2, 0, 0, ALU_SUB, 'b10010, 3, 0, 1, 1, 0, 0, 0, 0},
    '{32'h40c5d533, 2, 1, 0, 0, ALU_SRA, 'b10010, 3, 0, 1, 1, 0, 0, 0, 0},
    '{32'hffb48213, 1, 0, 0, 0, ALU_ADD, 'b10010, 1, 0, 1, 2, 32'hfffffffb, 0, 0, 0},
    '{32'h1230c413, 2, 0, 0, 0, ALU_XOR, 'b10010, 1, 0, 1, 2, 32'h123, 0, 0, 0},
    '{32'h01012303, 0, 0, 0, 0, ALU_ADD, 'b01010, 1, 'b110, 1, 2, 32'h10, 0, 0, 0},
    '{32'hfff1c383, 1, 0, 0, 0, ALU_ADD, 'b01010, 1, 'b000, 1, 2, 32'hffffffff, 0, 0, 0},
    '{32'h00522423, 0, 2, 0, 0, ALU_ADD, 'b01100, 3, 'b110, 1, 2, 32'h8, 1, 0, 0},
    '{32'h123454b7, 0, 0, 0, 0, ALU_ADD, 'b10010, 0, 0, 3, 2, 32'h12345000, 0, 0, 0},
    '{32'hfffff097, 0, 0, 0, 0, ALU_ADD, 'b10010, 0, 0, 2, 2, 32'hfffff000, 0, 0, 0},
    '{32'h00208863, 0, 1, 0, 0, ALU_EQ, 'b10000, 3, 0, 1, 1, 0, 2, 32'h10, 0},
    '{32'hfe419ce3, 2, 2, 3, 0, ALU_NE, 'b10000, 3, 0, 1, 1, 0, 2, 32'hfffffff8, 0},
    '{32'h001000ef, 0, 0, 0, 0, ALU_ADD, 'b10010, 0, 0, 2, 2, 32'h4, 0, 32'h800, 1},
    '{32'h00c28167, 1, 0, 0, 0, ALU_ADD, 'b10010, 1, 0, 2, 2, 32'h4, 0, 32'hc, 2},
    '{32'h0020c863, 0, 0, 0, 1, ALU_LT, 'b10000, 3, 0, 1, 1, 0, 2, 32'h10, 0},
    '{32'h0020f863, 2, 2, 0, 0, ALU_GEU, 'b10000, 3, 0, 1, 1, 0, 2, 32'h10, 0},
    '{32'h0000007f, 0, 0, 0, 0, ALU_ADD, 'b00001, 3, 0, 0, 0, 0, 0, 0, 0},
    '{32'h0032d213, 0, 0, 2, 0, ALU_SRL, 'b10010, 1, 0, 1, 2, 32'h3, 0, 0, 0}
  };

  logic clk, rst_n, instr_valid_i, kill_id_i, halt_id_i, ex_ready_i;
  logic [31:0] instr_i, pc_i, rf_rdata_a_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i;
  fw_sel_e fw_a_sel_i, fw_b_sel_i;
  rf_addr_t rf_raddr_a_o, rf_raddr_b_o, ex_rf_waddr_o;
  logic [1:0] rf_re_o, ex_lsu_size_o;
  logic [31:0] jmp_target_o, ex_operand_a_o, ex_operand_b_o, ex_operand_c_o, ex_pc_o;
  logic id_ready_o, id_valid_o, ex_valid_o, ex_alu_en_o, ex_bch_o, ex_jmp_o;
  logic ex_lsu_en_o, ex_lsu_we_o, ex_lsu_sext_o, ex_rf_we_o, ex_illegal_o;
  logic ex_first_op_o, ex_last_op_o;
  alu_op_e ex_alu_op_o;
  logic [31:0] lfsr_q = 32'hf8dc0195;
  int errors = 0;

  id_stage i_id_stage (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] pick_source(input int sel, input logic [31:0] rf, ex, wb);
    return (sel == 1) ? ex : (sel == 2) ? wb : rf;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t r;
    logic [31:0] pc, ra, rb, wex, wwb, rs1, rs2, m_a, m_b, m_c, held_pc;
    logic [2:0] m_lsu;
    logic m_we, held_valid, m_bch, m_jmp;
    rf_addr_t m_wa;
    alu_op_e m_op;
    int nops, ops;
    // Expected ID/EX contents after reset
    m_a = '0;
    m_b = '0;
    m_c = '0;
    m_lsu = '0;
    m_we = 1'b0;
    m_wa = '0;
    m_op = ALU_SLTU;
    m_bch = 1'b0;
    m_jmp = 1'b0;
    rst_n = 1'b0;
    instr_valid_i = 1'b0;
    kill_id_i = 1'b0;
    halt_id_i = 1'b0;
    ex_ready_i = 1'b1;
    instr_i = '0;
    pc_i = '0;
    fw_a_sel_i = SEL_REGFILE;
    fw_b_sel_i = SEL_REGFILE;
    rf_rdata_a_i = '0;
    rf_rdata_b_i = '0;
    rf_wdata_ex_i = '0;
    rf_wdata_wb_i = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Empty ID/EX register right after reset
    @(negedge clk);
    compare("ex_valid_o", 32'(ex_valid_o), 32'h0);
    compare("ex_alu_en_o", 32'(ex_alu_en_o), 32'h0);
    compare("ex_first_op_o", 32'(ex_first_op_o), 32'h0);
    compare("ex_last_op_o", 32'(ex_last_op_o), 32'h0);
    compare("ex_alu_op_o", 32'(ex_alu_op_o), 32'(m_op));
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = rows[i];
      pc = 32'h1000 + 32'h40 * i;
      rand_word(ra);
      rand_word(rb);
      rand_word(wex);
      rand_word(wwb);
      rs1 = pick_source(r.fwa, ra, wex, wwb);
      rs2 = pick_source(r.fwb, rb, wex, wwb);
      // Jumps and branches go to EX twice
      nops = (r.tsrc != 0 || r.csrc == 2) ? 2 : 1;
      ops = (r.kill != 0) ? 1 : nops;
      @(posedge clk);
      instr_valid_i <= 1'b1;
      instr_i <= r.instr;
      pc_i <= pc;
      fw_a_sel_i <= fw_sel_e'(r.fwa[1:0]);
      fw_b_sel_i <= fw_sel_e'(r.fwb[1:0]);
      rf_rdata_a_i <= ra;
      rf_rdata_b_i <= rb;
      rf_wdata_ex_i <= wex;
      rf_wdata_wb_i <= wwb;
      ex_ready_i <= (r.stall == 0);
      @(negedge clk);
      compare("rf_raddr_a_o", 32'(rf_raddr_a_o), 32'(r.instr[19:15]));
      compare("rf_raddr_b_o", 32'(rf_raddr_b_o), 32'(r.instr[24:20]));
      compare("rf_re_o", 32'(rf_re_o), 32'(r.re));
      if (r.tsrc == 1) compare("jmp_target_o", jmp_target_o, pc + r.off);
      if (r.tsrc == 2) compare("jmp_target_o", jmp_target_o, (rs1 + r.off) & ~32'h1);
      // EX stalls and the ID/EX register holds
      held_pc = ex_pc_o;
      held_valid = ex_valid_o;
      for (int s = 0; s < r.stall; s++) begin
        compare("id_ready_o", 32'(id_ready_o), 32'h0);
        compare("id_valid_o", 32'(id_valid_o), 32'h1);
        compare("ex_pc_o", ex_pc_o, held_pc);
        compare("ex_valid_o", 32'(ex_valid_o), 32'(held_valid));
        @(posedge clk);
        if (s == r.stall - 1) ex_ready_i <= 1'b1;
        @(negedge clk);
      end
      for (int op = 0; op < ops; op++) begin
        while (!(id_valid_o && ex_ready_i)) @(negedge clk);
        compare("id_ready_o", 32'(id_ready_o), 32'(op == nops - 1));
        @(posedge clk);
        if (op == ops - 1) begin
          instr_valid_i <= 1'b0;
          kill_id_i <= (r.kill != 0);
          // A stalled row meets the previous entry still held in EX
          ex_ready_i <= (i == NUM_ROWS - 1) || (rows[i + 1].stall == 0);
        end
        if (r.asrc == 1) m_a = rs1;
        else if (r.asrc == 2) m_a = pc;
        else if (r.asrc == 3) m_a = '0;
        if (r.bsrc == 1) m_b = rs2;
        else if (r.bsrc == 2) m_b = r.bimm;
        if (r.csrc == 1) m_c = rs2;
        else if (r.csrc == 2) m_c = pc + r.off;
        if (r.en[4]) begin
          m_op = r.op;
          m_bch = (r.csrc == 2);
          m_jmp = (r.tsrc != 0);
        end
        if (r.en[3]) begin
          m_we = r.en[2];
          m_lsu = r.lsu[2:0];
        end
        if (r.en[1]) m_wa = r.instr[11:7];
        @(negedge clk);
        compare("ex_valid_o", 32'(ex_valid_o), 32'h1);
        compare("ex_alu_en_o", 32'(ex_alu_en_o), 32'(r.en[4]));
        compare("ex_bch_o", 32'(ex_bch_o), 32'(m_bch));
        compare("ex_jmp_o", 32'(ex_jmp_o), 32'(m_jmp));
        compare("ex_lsu_en_o", 32'(ex_lsu_en_o), 32'(r.en[3]));
        compare("ex_lsu_we_o", 32'(ex_lsu_we_o), 32'(m_we));
        compare("ex_rf_we_o", 32'(ex_rf_we_o), 32'(r.en[1]));
        compare("ex_illegal_o", 32'(ex_illegal_o), 32'(r.en[0]));
        compare("ex_first_op_o", 32'(ex_first_op_o), 32'(op == 0));
        compare("ex_last_op_o", 32'(ex_last_op_o), 32'(op == nops - 1));
        compare("ex_alu_op_o", 32'(ex_alu_op_o), 32'(m_op));
        compare("ex_lsu_size_o", 32'(ex_lsu_size_o), 32'(m_lsu[1:0]));
        compare("ex_lsu_sext_o", 32'(ex_lsu_sext_o), 32'(m_lsu[2]));
        compare("ex_operand_a_o", ex_operand_a_o, m_a);
        compare("ex_operand_b_o", ex_operand_b_o, m_b);
        compare("ex_operand_c_o", ex_operand_c_o, m_c);
        compare("ex_pc_o", ex_pc_o, pc);
        compare("ex_rf_waddr_o", 32'(ex_rf_waddr_o), 32'(m_wa));
      end
      // Kill drops the second op and clears the counter
      if (r.kill != 0) begin
        @(posedge clk);
        kill_id_i <= 1'b0;
      end
    end
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog with a fixed cycle budget per table row
  initial begin
    #(2 * CLK_HALF * (NUM_ROWS * ROW_LIMIT + 8));
    $display("Timeout: the table did not complete within the cycle limit");
    $display("Done: errors found");
    $fatal(1);
  end

endmodule

/* testbench/id_stage_chk.sv */
`timescale 1ns/1ns

module id_stage_chk (
  input logic        clk,
  input logic        rst_n,
  input logic        transfer_i,
  input logic        first_op_i,
  input logic        last_op_i,
  input logic        id_ready_i,
  input logic        ex_valid_i,
  input logic        ex_ready_i,
  input logic [31:0] ex_pc_i,
  input logic [31:0] ex_operand_a_i,
  input logic [31:0] ex_operand_b_i,
  input logic [31:0] ex_operand_c_i
);

  // No valid entry in EX during and right after reset
  a_reset_valid: assert property (@(posedge clk) !rst_n |-> !ex_valid_i)
    else $error("ex_valid_o high during reset");
  a_release_valid: assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid_i)
    else $error("ex_valid_o high right after reset");

  // First op of a jump or branch keeps the instruction in ID
  a_first_op_ready: assert property (@(posedge clk) disable iff (!rst_n)
    transfer_i && first_op_i && !last_op_i |-> !id_ready_i)
    else $error("id_ready_o high on a first jump or branch op");

  // Back-pressure from EX freezes the ID/EX register
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i && !ex_ready_i |=> $stable(ex_pc_i) && $stable(ex_operand_a_i) &&
    $stable(ex_operand_b_i) && $stable(ex_operand_c_i))
    else $error("ex_ outputs changed while EX stalled");

endmodule

bind id_stage id_stage_chk i_id_stage_chk (
  .clk(clk), .rst_n(rst_n), .transfer_i(transfer), .first_op_i(first_op),
  .last_op_i(last_op), .id_ready_i(id_ready_o), .ex_valid_i(ex_valid_o),
  .ex_ready_i(ex_ready_i), .ex_pc_i(ex_pc_o), .ex_operand_a_i(ex_operand_a_o),
  .ex_operand_b_i(ex_operand_b_o), .ex_operand_c_i(ex_operand_c_o)
);

/* design/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_valid_i,
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic                    kill_id_i,
  input  logic                    halt_id_i,
  input  logic                    ex_ready_i,
  input  id_pkg::fw_sel_e         fw_a_sel_i,
  input  id_pkg::fw_sel_e         fw_b_sel_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_b_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_wb_i,
  output id_pkg::rf_addr_t        rf_raddr_a_o,
  output id_pkg::rf_addr_t        rf_raddr_b_o,
  output logic [1:0]              rf_re_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o,
  output logic                    id_ready_o,
  output logic                    id_valid_o,
  output logic                    ex_valid_o,
  output logic                    ex_alu_en_o,
  output logic                    ex_bch_o,
  output logic                    ex_jmp_o,
  output logic                    ex_lsu_en_o,
  output logic                    ex_lsu_we_o,
  output logic                    ex_lsu_sext_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output logic                    ex_first_op_o,
  output logic                    ex_last_op_o,
  output id_pkg::alu_op_e         ex_alu_op_o,
  output logic [1:0]              ex_lsu_size_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_c_o,
  output logic [id_pkg::XLEN-1:0] ex_pc_o,
  output id_pkg::rf_addr_t        ex_rf_waddr_o
);
  import id_pkg::*;

  logic [XLEN-1:0] operand_a, operand_b, operand_c;
  rf_addr_t        rf_waddr;
  logic            first_op, last_op;
  logic            transfer;

  id_ctrl_if ctrl_if ();

  // Register fields
  assign rf_raddr_a_o = instr_i[REG_S1_LSB +: REG_ADDR_W];
  assign rf_raddr_b_o = instr_i[REG_S2_LSB +: REG_ADDR_W];
  assign rf_waddr     = instr_i[REG_D_LSB +: REG_ADDR_W];

  // Handshake with EX
  assign transfer = id_valid_o && ex_ready_i;

  id_decoder i_id_decoder (.instr_i(instr_i), .rf_re_o(rf_re_o), .ctrl(ctrl_if.dec));

  id_operands i_id_operands (
    .instr_i      (instr_i),       .pc_i         (pc_i),
    .rf_rdata_a_i (rf_rdata_a_i),  .rf_rdata_b_i (rf_rdata_b_i),
    .rf_wdata_ex_i(rf_wdata_ex_i), .rf_wdata_wb_i(rf_wdata_wb_i),
    .fw_a_sel_i   (fw_a_sel_i),    .fw_b_sel_i   (fw_b_sel_i),
    .ctrl         (ctrl_if.opnd),
    .operand_a_o  (operand_a),     .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),     .jmp_target_o (jmp_target_o)
  );

  id_flow_ctrl i_id_flow_ctrl (
    .clk       (clk),        .rst_n        (rst_n),
    .instr_valid_i(instr_valid_i), .kill_id_i(kill_id_i),
    .halt_id_i (halt_id_i),  .ex_ready_i   (ex_ready_i),
    .ctrl      (ctrl_if.flow),
    .id_ready_o(id_ready_o), .id_valid_o   (id_valid_o),
    .first_op_o(first_op),   .last_op_o    (last_op)
  );

  id_ex_pipe i_id_ex_pipe (
    .clk           (clk),            .rst_n         (rst_n),
    .transfer_i    (transfer),       .ex_ready_i    (ex_ready_i),
    .ctrl          (ctrl_if.pipe),
    .operand_a_i   (operand_a),      .operand_b_i   (operand_b),
    .operand_c_i   (operand_c),      .pc_i          (pc_i),
    .rf_waddr_i    (rf_waddr),
    .first_op_i    (first_op),       .last_op_i     (last_op),
    .ex_valid_o    (ex_valid_o),     .ex_alu_en_o   (ex_alu_en_o),
    .ex_bch_o      (ex_bch_o),       .ex_jmp_o      (ex_jmp_o),
    .ex_lsu_en_o   (ex_lsu_en_o),    .ex_lsu_we_o   (ex_lsu_we_o),
    .ex_lsu_sext_o (ex_lsu_sext_o),  .ex_rf_we_o    (ex_rf_we_o),
    .ex_illegal_o  (ex_illegal_o),   .ex_first_op_o (ex_first_op_o),
    .ex_last_op_o  (ex_last_op_o),   .ex_alu_op_o   (ex_alu_op_o),
    .ex_lsu_size_o (ex_lsu_size_o),  .ex_operand_a_o(ex_operand_a_o),
    .ex_operand_b_o(ex_operand_b_o), .ex_operand_c_o(ex_operand_c_o),
    .ex_pc_o       (ex_pc_o),        .ex_rf_waddr_o (ex_rf_waddr_o)
  );

endmodule

/* design/id_ex_pipe.sv */
`timescale 1ns/1ns

module id_ex_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    transfer_i,
  input  logic                    ex_ready_i,
  id_ctrl_if.pipe                 ctrl,
  input  logic [id_pkg::XLEN-1:0] operand_a_i,
  input  logic [id_pkg::XLEN-1:0] operand_b_i,
  input  logic [id_pkg::XLEN-1:0] operand_c_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  id_pkg::rf_addr_t        rf_waddr_i,
  input  logic                    first_op_i,
  input  logic                    last_op_i,
  output logic                    ex_valid_o,
  output logic                    ex_alu_en_o,
  output logic                    ex_bch_o,
  output logic                    ex_jmp_o,
  output logic                    ex_lsu_en_o,
  output logic                    ex_lsu_we_o,
  output logic                    ex_lsu_sext_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output logic                    ex_first_op_o,
  output logic                    ex_last_op_o,
  output id_pkg::alu_op_e         ex_alu_op_o,
  output logic [1:0]              ex_lsu_size_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0] ex_operand_c_o,
  output logic [id_pkg::XLEN-1:0] ex_pc_o,
  output id_pkg::rf_addr_t        ex_rf_waddr_o
);
  import id_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_bch_o       <= 1'b0;
      ex_jmp_o       <= 1'b0;
      ex_alu_op_o    <= ALU_SLTU;
      ex_lsu_en_o    <= 1'b0;
      ex_lsu_we_o    <= 1'b0;
      ex_lsu_size_o  <= 2'b00;
      ex_lsu_sext_o  <= 1'b0;
      ex_rf_we_o     <= 1'b0;
      ex_rf_waddr_o  <= '0;
      ex_illegal_o   <= 1'b0;
      ex_first_op_o  <= 1'b0;
      ex_last_op_o   <= 1'b0;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_pc_o        <= '0;
    end else if (transfer_i) begin
      ex_valid_o    <= 1'b1;
      ex_first_op_o <= first_op_i;
      ex_last_op_o  <= last_op_i;
      ex_pc_o       <= pc_i;
      ex_illegal_o  <= ctrl.illegal;

      // Operands only move when the instruction uses them
      if (ctrl.op_a_sel != OP_A_NONE) ex_operand_a_o <= operand_a_i;
      if (ctrl.op_b_sel != OP_B_NONE) ex_operand_b_o <= operand_b_i;
      if (ctrl.op_c_sel != OP_C_NONE) ex_operand_c_o <= operand_c_i;

      ex_alu_en_o <= ctrl.alu_en;
      if (ctrl.alu_en) begin
        ex_alu_op_o <= ctrl.alu_op;
        ex_bch_o    <= ctrl.alu_bch;
        // JALR counts as a jump too
        ex_jmp_o    <= ctrl.alu_jmp || ctrl.alu_jmpr;
      end

      ex_lsu_en_o <= ctrl.lsu_en;
      if (ctrl.lsu_en) begin
        ex_lsu_we_o   <= ctrl.lsu_we;
        ex_lsu_size_o <= ctrl.lsu_size;
        ex_lsu_sext_o <= ctrl.lsu_sext;
      end

      ex_rf_we_o <= ctrl.rf_we;
      if (ctrl.rf_we) ex_rf_waddr_o <= rf_waddr_i;
    end else if (ex_ready_i) begin
      // EX took the last entry, leave a bubble
      ex_valid_o <= 1'b0;
    end
  end

endmodule

/* design/id_flow_ctrl.sv */
`timescale 1ns/1ns

module id_flow_ctrl (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   instr_valid_i,
  input  logic   kill_id_i,
  input  logic   halt_id_i,
  input  logic   ex_ready_i,
  id_ctrl_if.flow ctrl,
  output logic   id_ready_o,
  output logic   id_valid_o,
  output logic   first_op_o,
  output logic   last_op_o
);
  import id_pkg::*;

  logic                      jmp_bch;
  logic [MULTI_OP_CNT_W-1:0] op_cnt;
  logic                      multi_op_stall;

  assign jmp_bch = ctrl.alu_en && (ctrl.alu_jmp || ctrl.alu_bch);

  // Single op instructions are both first and last
  assign first_op_o = jmp_bch ? (op_cnt == '0) : 1'b1;
  assign last_op_o  = jmp_bch ? (op_cnt == MULTI_OP_CNT_W'(JMP_BCH_CYCLES - 1)) : 1'b1;

  // Hold the instruction in ID until its last op goes out
  assign multi_op_stall = !last_op_o && instr_valid_i;

  assign id_ready_o = kill_id_i || (!multi_op_stall && ex_ready_i && !halt_id_i);
  assign id_valid_o = (instr_valid_i && !kill_id_i && !halt_id_i) ||
                      (multi_op_stall && !kill_id_i && !halt_id_i);

  // Ops sent for the current jump or branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_cnt <= '0;
    end else if (kill_id_i) begin
      op_cnt <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      // Wrap after the last op
      op_cnt <= last_op_o ? '0 : op_cnt + MULTI_OP_CNT_W'(1);
    end
  end

endmodule

/* design/id_operands.sv */
`timescale 1ns/1ns

module id_operands (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_b_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_wb_i,
  input  id_pkg::fw_sel_e         fw_a_sel_i,
  input  id_pkg::fw_sel_e         fw_b_sel_i,
  id_ctrl_if.opnd                 ctrl,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o,
  output logic [id_pkg::XLEN-1:0] operand_c_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);
  import id_pkg::*;

  logic [XLEN-1:0] imm_i, imm_s, imm_sb, imm_u, imm_j;
  logic [XLEN-1:0] imm_op_b;
  logic [XLEN-1:0] rs1_fw, rs2_fw;
  logic [XLEN-1:0] bch_target;
  logic [XLEN-1:0] jalr_sum;

  // Register file value or a result still in flight
  function automatic logic [XLEN-1:0] fw_mux(fw_sel_e sel, logic [XLEN-1:0] rf,
                                             logic [XLEN-1:0] ex, logic [XLEN-1:0] wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  // Sign extended immediates
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_j  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // JALR reads the same forwarded rs1 as operand A
  assign rs1_fw = fw_mux(fw_a_sel_i, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
  assign rs2_fw = fw_mux(fw_b_sel_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin
    case (ctrl.imm_b_sel)
      IMMB_S:      imm_op_b = imm_s;
      IMMB_U:      imm_op_b = imm_u;
      IMMB_PCINCR: imm_op_b = XLEN'(PC_INCR);
      default:     imm_op_b = imm_i;
    endcase

    case (ctrl.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw;
    endcase
  end

  assign operand_b_o = (ctrl.op_b_sel == OP_B_IMM) ? imm_op_b : rs2_fw;

  // Branch target rides to EX in operand C
  assign bch_target  = pc_i + imm_sb;
  assign operand_c_o = (ctrl.op_c_sel == OP_C_BCH) ? bch_target : rs2_fw;

  ////////////////////////////////////////////////////////////////////////////
  // Jump target
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 of the JALR sum is dropped
  assign jalr_sum     = rs1_fw + imm_i;
  assign jmp_target_o = (ctrl.tgt_sel == TGT_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                   : pc_i + imm_j;

endmodule

/* design/id_decoder.sv */
`timescale 1ns/1ns

module id_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  output logic [1:0]              rf_re_o,
  id_ctrl_if.dec                  ctrl
);
  import id_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [1:0] rf_re;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Defaults, nothing enabled
    ctrl.alu_en    = 1'b0;
    ctrl.alu_bch   = 1'b0;
    ctrl.alu_jmp   = 1'b0;
    ctrl.alu_jmpr  = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.op_a_sel  = OP_A_NONE;
    ctrl.op_b_sel  = OP_B_NONE;
    ctrl.imm_b_sel = IMMB_I;
    ctrl.op_c_sel  = OP_C_NONE;
    ctrl.tgt_sel   = TGT_JAL;
    ctrl.lsu_en    = 1'b0;
    ctrl.lsu_we    = 1'b0;
    ctrl.lsu_size  = funct3[1:0];
    ctrl.lsu_sext  = !funct3[2];
    ctrl.rf_we     = 1'b0;
    ctrl.illegal   = 1'b0;
    rf_re          = 2'b00;

    case (opcode)
      OPC_OP: begin
        ctrl.alu_en = 1'b1; ctrl.rf_we = 1'b1; rf_re = 2'b11;
        ctrl.op_a_sel = OP_A_REG;
        ctrl.op_b_sel = OP_B_REG;
        // funct7 picks SUB and SRA
        case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
          default:         ctrl.illegal = 1'b1;
        endcase
      end
      OPC_OPIMM: begin
        ctrl.alu_en = 1'b1; ctrl.rf_we = 1'b1; rf_re = 2'b01;
        ctrl.op_a_sel = OP_A_REG;
        ctrl.op_b_sel = OP_B_IMM;
        case (funct3)
          3'b000: ctrl.alu_op = ALU_ADD;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b111: ctrl.alu_op = ALU_AND;
          // Shifts by immediate keep the funct7 check
          3'b001: begin
            ctrl.alu_op  = ALU_SLL;
            ctrl.illegal = (funct7 != 7'h00);
          end
          default: begin
            ctrl.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            ctrl.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl.alu_en = 1'b1; ctrl.rf_we = 1'b1;
        ctrl.op_a_sel  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMMB_U;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value PC + 4 is computed in the ALU
        ctrl.alu_en = 1'b1; ctrl.alu_jmp = 1'b1; ctrl.rf_we = 1'b1;
        ctrl.op_a_sel  = OP_A_PC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMMB_PCINCR;
        if (opcode == OPC_JALR) begin
          ctrl.alu_jmpr = 1'b1; ctrl.tgt_sel = TGT_JALR; rf_re = 2'b01;
          ctrl.illegal  = (funct3 != 3'b000);
        end
      end
      OPC_BRANCH: begin
        ctrl.alu_en = 1'b1; ctrl.alu_bch = 1'b1; rf_re = 2'b11;
        ctrl.op_a_sel = OP_A_REG;
        ctrl.op_b_sel = OP_B_REG;
        ctrl.op_c_sel = OP_C_BCH;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // LB, LH, LW, LBU, LHU only
        ctrl.lsu_en = 1'b1; ctrl.rf_we = 1'b1; rf_re = 2'b01;
        ctrl.op_a_sel = OP_A_REG;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.illegal  = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl.lsu_en = 1'b1; ctrl.lsu_we = 1'b1; rf_re = 2'b11;
        ctrl.op_a_sel  = OP_A_REG;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMMB_S;
        ctrl.op_c_sel  = OP_C_REG;
        ctrl.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // Illegal encodings do no work in EX
    if (ctrl.illegal) begin
      ctrl.alu_en  = 1'b0; ctrl.alu_bch = 1'b0; ctrl.alu_jmp = 1'b0;
      ctrl.alu_jmpr = 1'b0; ctrl.lsu_en = 1'b0; ctrl.lsu_we = 1'b0;
      ctrl.rf_we   = 1'b0;
    end
  end

  // Read both sources for an illegal instruction
  assign rf_re_o = ctrl.illegal ? 2'b11 : rf_re;

endmodule

/* design/id_ctrl_if.sv */
`timescale 1ns/1ns

// Decoded control bundle of the instruction in ID
interface id_ctrl_if;
  import id_pkg::*;

  // ALU control
  logic       alu_en;
  logic       alu_bch;
  logic       alu_jmp;
  logic       alu_jmpr;
  alu_op_e    alu_op;

  // Operand mux selects
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  op_c_sel_e  op_c_sel;
  tgt_sel_e   tgt_sel;

  // LSU control
  logic       lsu_en;
  logic       lsu_we;
  logic [1:0] lsu_size;
  logic       lsu_sext;

  // Write back and exception
  logic       rf_we;
  logic       illegal;

  modport dec  (output alu_en, alu_bch, alu_jmp, alu_jmpr, alu_op, op_a_sel, op_b_sel,
                imm_b_sel, op_c_sel, tgt_sel, lsu_en, lsu_we, lsu_size, lsu_sext,
                rf_we, illegal);
  modport opnd (input op_a_sel, op_b_sel, imm_b_sel, op_c_sel, tgt_sel);
  modport pipe (input alu_en, alu_bch, alu_jmp, alu_jmpr, alu_op, op_a_sel, op_b_sel,
                op_c_sel, lsu_en, lsu_we, lsu_size, lsu_sext, rf_we, illegal);
  modport flow (input alu_en, alu_bch, alu_jmp);

endinterface

/* design/id_pkg.sv */
package id_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and instruction field positions
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Low bit of each register field, every field is REG_ADDR_W wide
  localparam int REG_S1_LSB = 15;
  localparam int REG_S2_LSB = 20;
  localparam int REG_D_LSB  = 7;

  // Hardened control flow, each jump or branch goes to EX twice
  localparam int JMP_BCH_CYCLES = 2;
  localparam int MULTI_OP_CNT_W = 1;

  // Link value added to the PC by JAL and JALR
  localparam int PC_INCR = 4;

  typedef logic [REG_ADDR_W-1:0] rf_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // RV32I major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OPIMM  = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic ops first, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Source of a register operand
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;

  // Operand muxes, NONE keeps the old operand in the ID/EX register
  typedef enum logic [1:0] {OP_A_NONE, OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_NONE, OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {OP_C_NONE, OP_C_REG, OP_C_BCH} op_c_sel_e;

  // Jump target source
  typedef enum logic {TGT_JAL, TGT_JALR} tgt_sel_e;

endpackage
